// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int LANE_BYTES = DATA_WIDTH / 8;
    localparam int LANE_BITS  = $clog2(LANE_BYTES);  // byte offset inside a dword

    // encoding is log2 of the byte count
    typedef enum logic [1:0] {
        LEN_BYTE  = 2'd0,
        LEN_HALF  = 2'd1,
        LEN_WORD  = 2'd2,
        LEN_DWORD = 2'd3
    } access_len_e;

    typedef logic [DATA_WIDTH-1:0] data_t;

    typedef struct packed {
        logic                  rd_en;
        logic                  wr_en;
        logic [ADDR_WIDTH-1:0] addr;
        access_len_e           len;
        data_t                 wdata;
    } lsu_req_t;

    typedef struct packed {
        logic                            is_store;
        logic [ADDR_WIDTH-LANE_BITS-1:0] line_addr;  // tag and index
        logic [LANE_BITS-1:0]            offset;     // already aligned
        access_len_e                     len;
        logic [LANE_BYTES-1:0]           byte_mask;
        data_t                           lane_data;  // store data in its lanes
    } aligned_req_t;

    // bytes touched by an access that starts at lane 0
    function automatic logic [LANE_BYTES-1:0] len_byte_mask(access_len_e len);
        case (len)
            LEN_BYTE: return 8'h01;
            LEN_HALF: return 8'h03;
            LEN_WORD: return 8'h0f;
            default:  return 8'hff;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    ////////////////////
    // geometry
    ////////////////////
    localparam int LINE_WIDTH  = lsu_pkg::DATA_WIDTH;  // one dword per line
    localparam int LINE_BYTES  = LINE_WIDTH / 8;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int INDEX_BITS  = 6;
    localparam int SETS        = 1 << INDEX_BITS;
    localparam int TAG_BITS    = lsu_pkg::ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    typedef logic [LINE_WIDTH-1:0]          line_t;
    typedef logic [TAG_BITS-1:0]            tag_t;
    typedef logic [INDEX_BITS-1:0]          index_t;
    typedef logic [TAG_BITS+INDEX_BITS-1:0] line_addr_t;

    ////////////////////
    // controller
    ////////////////////
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // lookup
        ST_WTBK = 2'd1,  // dirty victim to memory
        ST_MISS = 2'd2,  // refill read
        ST_DONE = 2'd3   // lookup after fill
    } miss_state_e;

    typedef struct packed {
        logic                           rd_en;
        logic                           wr_en;
        logic [lsu_pkg::ADDR_WIDTH-1:0] addr;   // byte address of the line
        line_t                          wdata;
    } mem_req_t;

    function automatic logic [lsu_pkg::ADDR_WIDTH-1:0] line_base_addr(line_addr_t line_addr);
        return {line_addr, {OFFSET_BITS{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== lsu_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
    input  logic                  clk,
    input  logic                  reset,
    input  lsu_pkg::lsu_req_t     req,
    input  logic                  complete,
    output lsu_pkg::aligned_req_t areq,
    output logic                  req_valid
);

    logic                          start;
    logic [lsu_pkg::LANE_BITS-1:0] align_keep;
    logic [lsu_pkg::LANE_BITS-1:0] offset;
    lsu_pkg::aligned_req_t         next_areq;

    // one request at a time, taken only while idle
    assign start = !req_valid && (req.rd_en || req.wr_en);

    // low offset bits below the access size are dropped
    assign align_keep = {lsu_pkg::LANE_BITS{1'b1}} << req.len;
    assign offset     = req.addr[lsu_pkg::LANE_BITS-1:0] & align_keep;

    always_comb begin
        next_areq.is_store  = req.wr_en;
        next_areq.line_addr = req.addr[lsu_pkg::ADDR_WIDTH-1:lsu_pkg::LANE_BITS];
        next_areq.offset    = offset;
        next_areq.len       = req.len;
        next_areq.byte_mask = lsu_pkg::len_byte_mask(req.len) << offset;
        next_areq.lane_data = req.wdata << {offset, 3'b000};  // bytes to bits
    end

    ////////////////////
    // request register
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else if (req_valid) begin
            if (complete) begin
                req_valid <= 1'b0;  // free for the next request
            end
        end else if (start) begin
            req_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            areq <= next_areq;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
    input  logic                   clk,
    input  logic                   reset,
    input  lsu_pkg::aligned_req_t  areq,
    input  logic                   req_valid,
    input  logic                   store_we,
    input  logic                   fill_we,
    input  logic                   fill_dirty,
    input  dcache_pkg::line_t      mem_rdata,
    output logic                   hit,
    output dcache_pkg::line_t      line_data,
    output logic                   victim_dirty,
    output dcache_pkg::line_addr_t victim_line_addr
);

    dcache_pkg::tag_t            tag_mem  [dcache_pkg::SETS];
    dcache_pkg::line_t           data_mem [dcache_pkg::SETS];
    logic [dcache_pkg::SETS-1:0] valid_bits;
    logic [dcache_pkg::SETS-1:0] dirty_bits;

    dcache_pkg::index_t index;
    dcache_pkg::tag_t   req_tag;
    dcache_pkg::line_t  merged_line;

    assign index   = areq.line_addr[dcache_pkg::INDEX_BITS-1:0];
    assign req_tag = areq.line_addr[dcache_pkg::INDEX_BITS +: dcache_pkg::TAG_BITS];

    ////////////////////
    // lookup
    ////////////////////
    assign line_data        = data_mem[index];
    assign hit              = req_valid && valid_bits[index] && (tag_mem[index] == req_tag);
    assign victim_dirty     = valid_bits[index] && dirty_bits[index];
    assign victim_line_addr = {tag_mem[index], index};

    // store bytes over the resident line
    always_comb begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            merged_line[b*8 +: 8] = areq.byte_mask[b] ? areq.lane_data[b*8 +: 8]
                                                      : line_data[b*8 +: 8];
        end
    end

    ////////////////////
    // update
    ////////////////////
    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[index] <= mem_rdata;
            tag_mem[index]  <= req_tag;
        end else if (store_we) begin
            data_mem[index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_we) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= fill_dirty;  // set when refilling for a store
        end else if (store_we) begin
            dirty_bits[index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  lsu_pkg::aligned_req_t  areq,
    input  logic                   req_valid,
    input  logic                   hit,
    input  logic                   victim_dirty,
    input  dcache_pkg::line_addr_t victim_line_addr,
    input  dcache_pkg::line_t      line_data,
    input  logic                   mem_wr_ready,
    input  logic                   mem_rd_valid,
    output dcache_pkg::mem_req_t   mem_req,
    output logic                   store_we,
    output logic                   fill_we,
    output logic                   fill_dirty,
    output logic                   load_rsp,
    output logic                   complete
);

    dcache_pkg::miss_state_e state;
    dcache_pkg::miss_state_e state_next;
    logic                    lookup;

    // a hit counts in idle and right after a fill
    assign lookup = req_valid && hit &&
                    ((state == dcache_pkg::ST_IDLE) || (state == dcache_pkg::ST_DONE));

    assign complete   = lookup;
    assign store_we   = lookup && areq.is_store;
    assign load_rsp   = lookup && !areq.is_store;
    assign fill_we    = (state == dcache_pkg::ST_MISS) && mem_rd_valid;
    assign fill_dirty = areq.is_store;

    ////////////////////
    // state machine
    ////////////////////
    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::ST_IDLE: begin
                if (req_valid && !hit) begin
                    state_next = victim_dirty ? dcache_pkg::ST_WTBK : dcache_pkg::ST_MISS;
                end
            end
            dcache_pkg::ST_WTBK: begin
                if (mem_wr_ready) begin
                    state_next = dcache_pkg::ST_MISS;
                end
            end
            dcache_pkg::ST_MISS: begin
                if (mem_rd_valid) begin
                    state_next = dcache_pkg::ST_DONE;
                end
            end
            default: begin
                state_next = dcache_pkg::ST_IDLE;  // idle retries if still no hit
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////
    // memory port
    ////////////////////
    // enables held for the whole state, dropped after the handshake pulse
    always_comb begin
        mem_req.rd_en = (state == dcache_pkg::ST_MISS);
        mem_req.wr_en = (state == dcache_pkg::ST_WTBK);
        if (state == dcache_pkg::ST_WTBK) begin
            mem_req.addr = dcache_pkg::line_base_addr(victim_line_addr);
        end else begin
            mem_req.addr = dcache_pkg::line_base_addr(areq.line_addr);
        end
        mem_req.wdata = line_data;  // victim line, set untouched during write-back
    end

endmodule

`default_nettype wire

// ==== lsu_load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extract (
    input  logic                  clk,
    input  logic                  reset,
    input  lsu_pkg::aligned_req_t areq,
    input  logic                  load_rsp,
    input  logic                  complete,
    input  dcache_pkg::line_t     line_data,
    output logic                  done,
    output lsu_pkg::data_t        rdata
);

    logic [lsu_pkg::LANE_BYTES-1:0] len_bytes;
    lsu_pkg::data_t                 len_mask;
    lsu_pkg::data_t                 shifted;

    assign len_bytes = lsu_pkg::len_byte_mask(areq.len);
    assign shifted   = line_data >> {areq.offset, 3'b000};

    // byte mask widened to bits, zero-extends the result
    always_comb begin
        for (int b = 0; b < lsu_pkg::LANE_BYTES; b++) begin
            len_mask[b*8 +: 8] = {8{len_bytes[b]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= complete;  // complete is a single-cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            rdata <= load_rsp ? (shifted & len_mask) : '0;  // zero for stores
        end
    end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                 clk,
    input  logic                 reset,
    input  lsu_pkg::lsu_req_t    req,
    output logic                 done,
    output lsu_pkg::data_t       rdata,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_wr_ready,
    input  logic                 mem_rd_valid,
    input  dcache_pkg::line_t    mem_rdata
);

    lsu_pkg::aligned_req_t  areq;
    logic                   req_valid;
    logic                   complete;
    logic                   hit;
    dcache_pkg::line_t      line_data;
    logic                   victim_dirty;
    dcache_pkg::line_addr_t victim_line_addr;
    logic                   store_we;
    logic                   fill_we;
    logic                   fill_dirty;
    logic                   load_rsp;

    lsu_align u_align (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .complete  (complete),
        .areq      (areq),
        .req_valid (req_valid)
    );

    dcache_array u_array (
        .clk              (clk),
        .reset            (reset),
        .areq             (areq),
        .req_valid        (req_valid),
        .store_we         (store_we),
        .fill_we          (fill_we),
        .fill_dirty       (fill_dirty),
        .mem_rdata        (mem_rdata),
        .hit              (hit),
        .line_data        (line_data),
        .victim_dirty     (victim_dirty),
        .victim_line_addr (victim_line_addr)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk              (clk),
        .reset            (reset),
        .areq             (areq),
        .req_valid        (req_valid),
        .hit              (hit),
        .victim_dirty     (victim_dirty),
        .victim_line_addr (victim_line_addr),
        .line_data        (line_data),
        .mem_wr_ready     (mem_wr_ready),
        .mem_rd_valid     (mem_rd_valid),
        .mem_req          (mem_req),
        .store_we         (store_we),
        .fill_we          (fill_we),
        .fill_dirty       (fill_dirty),
        .load_rsp         (load_rsp),
        .complete         (complete)
    );

    lsu_load_extract u_load_extract (
        .clk       (clk),
        .reset     (reset),
        .areq      (areq),
        .load_rsp  (load_rsp),
        .complete  (complete),
        .line_data (line_data),
        .done      (done),
        .rdata     (rdata)
    );

endmodule

`default_nettype wire

// ==== lsu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_properties (
    input logic                 clk,
    input logic                 reset,
    input logic                 done,
    input dcache_pkg::mem_req_t mem_req,
    input logic                 mem_rd_valid
);

    int fail_count = 0;

    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            fail_count++;
            $error("done high in two consecutive cycles");
        end

    mem_excl: assert property (@(posedge clk) disable iff (reset)
                               !(mem_req.rd_en && mem_req.wr_en))
        else begin
            fail_count++;
            $error("memory read and write enables high together");
        end

    // read held until the data pulse
    rd_hold: assert property (@(posedge clk) disable iff (reset)
                              mem_req.rd_en && !mem_rd_valid |=> mem_req.rd_en)
        else begin
            fail_count++;
            $error("memory read enable dropped before mem_rd_valid");
        end

endmodule

bind lsu_top lsu_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .done         (done),
    .mem_req      (mem_req),
    .mem_rd_valid (mem_rd_valid)
);

`default_nettype wire

// ==== lsu_tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== lsu_tb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb_memory (
    input  logic                 clk,
    input  logic                 reset,
    input  dcache_pkg::mem_req_t mem_req,
    output logic                 mem_wr_ready,
    output logic                 mem_rd_valid,
    output dcache_pkg::line_t    mem_rdata
);

    dcache_pkg::line_t lines [dcache_pkg::line_addr_t];  // written lines only
    int unsigned       delay;

    // initial content from the low address byte
    function automatic logic [7:0] pattern_byte(logic [31:0] a);
        return a[7:0] ^ 8'h5a;
    endfunction

    function automatic dcache_pkg::line_t read_line(dcache_pkg::line_addr_t line_addr);
        dcache_pkg::line_t value;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            value[b*8 +: 8] = pattern_byte({line_addr, 3'(b)});
        end
        return value;
    endfunction

    initial begin
        mem_wr_ready = 1'b0;
        mem_rd_valid = 1'b0;
        mem_rdata    = '0;
        void'($urandom(15));
        forever begin
            @(negedge clk);
            if (!reset && (mem_req.rd_en || mem_req.wr_en)) begin
                delay = 1 + ($urandom % 6);
                repeat (delay - 1) @(negedge clk);
                if (mem_req.wr_en) begin
                    lines[mem_req.addr[31:3]] = mem_req.wdata;
                    mem_wr_ready = 1'b1;
                end else begin
                    mem_rdata    = read_line(mem_req.addr[31:3]);
                    mem_rd_valid = 1'b1;
                end
                @(negedge clk);
                mem_wr_ready = 1'b0;  // single-cycle pulse
                mem_rd_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int NUM_ROWS     = 17;
    localparam int DONE_TIMEOUT = 100;
    localparam int HIT_CYCLES   = 2;  // falling edges from drive to done on a hit

    typedef enum logic {OP_LOAD, OP_STORE} op_e;

    typedef struct packed {
        op_e                  op;
        logic [31:0]          addr;
        lsu_pkg::access_len_e len;
        lsu_pkg::data_t       wdata;
        logic                 hit_timed;    // line already resident
        logic                 wb_expected;  // dirty victim leaves
        logic [31:0]          wb_addr;
    } row_t;

    logic                   clk;
    logic                   reset;
    lsu_pkg::lsu_req_t      req;
    logic                   done;
    lsu_pkg::data_t         rdata;
    dcache_pkg::mem_req_t   mem_req;
    logic                   mem_wr_ready;
    logic                   mem_rd_valid;
    dcache_pkg::line_t      mem_rdata;
    row_t                   stim_table [NUM_ROWS];
    logic [7:0]             image [logic [31:0]];
    logic                   wb_seen;
    dcache_pkg::line_addr_t wb_line;
    int                     wait_count;

    lsu_tb_clock u_clock (.clk(clk), .reset(reset));

    lsu_tb_memory u_memory (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .mem_wr_ready (mem_wr_ready),
        .mem_rd_valid (mem_rd_valid),
        .mem_rdata    (mem_rdata)
    );

    lsu_top UUT (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .done         (done),
        .rdata        (rdata),
        .mem_req      (mem_req),
        .mem_wr_ready (mem_wr_ready),
        .mem_rd_valid (mem_rd_valid),
        .mem_rdata    (mem_rdata)
    );

    task automatic end_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(string name, lsu_pkg::data_t got, lsu_pkg::data_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_line_addr(string name, dcache_pkg::line_addr_t got,
                                   dcache_pkg::line_addr_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    function automatic logic [7:0] initial_byte(logic [31:0] a);
        return a[7:0] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] image_byte(logic [31:0] a);
        if (image.exists(a)) begin
            return image[a];
        end
        return initial_byte(a);
    endfunction

    // bytes from the aligned start packed low first and zero-extended
    function automatic lsu_pkg::data_t expected_load(logic [31:0] addr,
                                                     lsu_pkg::access_len_e len);
        int unsigned    nbytes;
        logic [31:0]    base;
        lsu_pkg::data_t value;
        nbytes = 1 << int'(len);
        base   = addr & ~(nbytes - 1);
        value  = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[i*8 +: 8] = image_byte(base + i);
        end
        return value;
    endfunction

    task automatic store_to_image(logic [31:0] addr, lsu_pkg::access_len_e len,
                                  lsu_pkg::data_t wdata);
        int unsigned nbytes;
        logic [31:0] base;
        nbytes = 1 << int'(len);
        base   = addr & ~(nbytes - 1);
        for (int i = 0; i < nbytes; i++) begin
            image[base + i] = wdata[i*8 +: 8];
        end
    endtask

    // called on a falling edge and returns on the one that shows done
    task automatic apply_row(row_t r, int idx);
        lsu_pkg::data_t exp_data;
        int             cycles;
        exp_data    = (r.op == OP_LOAD) ? expected_load(r.addr, r.len) : '0;
        req.rd_en   = (r.op == OP_LOAD);
        req.wr_en   = (r.op == OP_STORE);
        req.addr    = r.addr;
        req.len     = r.len;
        req.wdata   = r.wdata;
        wb_seen     = 1'b0;
        wb_line     = '0;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (mem_req.wr_en) begin
                wb_seen = 1'b1;
                wb_line = mem_req.addr[31:3];
            end
            if (cycles > DONE_TIMEOUT) begin
                $display("row %0d: no done from the unit within %0d cycles", idx, DONE_TIMEOUT);
                end_with_failure();
            end
        end while (!done);
        if (r.hit_timed && cycles != HIT_CYCLES) begin
            $display("row %0d: access to a resident line took %0d cycles", idx, cycles);
            end_with_failure();
        end
        check_data("rdata", rdata, exp_data);
        if (r.wb_expected) begin
            if (!wb_seen) begin
                $display("row %0d: the dirty victim was not written back", idx);
                end_with_failure();
            end
            check_line_addr("mem_req.addr", wb_line, r.wb_addr[31:3]);
        end else if (wb_seen) begin
            $display("row %0d: a memory write came without a dirty victim", idx);
            end_with_failure();
        end
        if (r.op == OP_STORE) begin
            store_to_image(r.addr, r.len, r.wdata);
        end
    endtask

    initial begin
        req = '0;
        ////////////////////
        // load misses at each length
        stim_table[0]  = '{OP_LOAD,  32'h0000_0013, lsu_pkg::LEN_BYTE,  64'h0, 1'b0, 1'b0, 32'h0};
        stim_table[1]  = '{OP_LOAD,  32'h0000_002a, lsu_pkg::LEN_HALF,  64'h0, 1'b0, 1'b0, 32'h0};
        stim_table[2]  = '{OP_LOAD,  32'h0000_0034, lsu_pkg::LEN_WORD,  64'h0, 1'b0, 1'b0, 32'h0};
        stim_table[3]  = '{OP_LOAD,  32'h0000_1238, lsu_pkg::LEN_DWORD, 64'h0, 1'b0, 1'b0, 32'h0};
        // resident line
        stim_table[4]  = '{OP_LOAD,  32'h0000_0034, lsu_pkg::LEN_WORD,  64'h0, 1'b1, 1'b0, 32'h0};
        stim_table[5]  = '{OP_LOAD,  32'h0000_0030, lsu_pkg::LEN_BYTE,  64'h0, 1'b1, 1'b0, 32'h0};
        ////////////////////
        // stores merged into lines
        stim_table[6]  = '{OP_STORE, 32'h0000_0101, lsu_pkg::LEN_BYTE,  64'ha5,
                           1'b0, 1'b0, 32'h0};
        stim_table[7]  = '{OP_STORE, 32'h0000_0102, lsu_pkg::LEN_HALF,  64'hbeef,
                           1'b1, 1'b0, 32'h0};
        stim_table[8]  = '{OP_STORE, 32'h0000_0104, lsu_pkg::LEN_WORD,  64'h1234_5678,
                           1'b1, 1'b0, 32'h0};
        stim_table[9]  = '{OP_LOAD,  32'h0000_0100, lsu_pkg::LEN_DWORD, 64'h0, 1'b1, 1'b0, 32'h0};
        stim_table[10] = '{OP_STORE, 32'h0000_0108, lsu_pkg::LEN_DWORD, 64'h0123_4567_89ab_cdef,
                           1'b0, 1'b0, 32'h0};
        stim_table[11] = '{OP_STORE, 32'h0000_010e, lsu_pkg::LEN_HALF,  64'h55aa,
                           1'b1, 1'b0, 32'h0};
        stim_table[12] = '{OP_LOAD,  32'h0000_0108, lsu_pkg::LEN_DWORD, 64'h0, 1'b1, 1'b0, 32'h0};
        ////////////////////
        // eviction of a dirty line by a new tag at the same index
        stim_table[13] = '{OP_STORE, 32'h0000_1040, lsu_pkg::LEN_WORD,  64'hcafe_f00d,
                           1'b0, 1'b0, 32'h0};
        stim_table[14] = '{OP_LOAD,  32'h0000_1240, lsu_pkg::LEN_DWORD, 64'h0,
                           1'b0, 1'b1, 32'h0000_1040};
        stim_table[15] = '{OP_LOAD,  32'h0000_1040, lsu_pkg::LEN_DWORD, 64'h0, 1'b0, 1'b0, 32'h0};
        stim_table[16] = '{OP_LOAD,  32'h0000_1044, lsu_pkg::LEN_WORD,  64'h0, 1'b1, 1'b0, 32'h0};

        wait_count = 0;
        do begin
            @(negedge clk);
            wait_count++;
            if (wait_count > 20) begin
                $display("reset was never released");
                end_with_failure();
            end
        end while (reset);

        // quiet after reset
        repeat (2) begin
            check_flag("done", done, 1'b0);
            check_flag("mem_req.rd_en", mem_req.rd_en, 1'b0);
            check_flag("mem_req.wr_en", mem_req.wr_en, 1'b0);
            @(negedge clk);
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(stim_table[i], i);
        end
        req = '0;
        repeat (2) @(negedge clk);

        if (UUT.u_props.fail_count != 0) begin
            $display("%0d assertion failures", UUT.u_props.fail_count);
            end_with_failure();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_top.f ====
lsu_pkg.sv
dcache_pkg.sv
lsu_align.sv
dcache_array.sv
dcache_miss_ctrl.sv
lsu_load_extract.sv
lsu_top.sv
lsu_properties.sv
lsu_tb_clock.sv
lsu_tb_memory.sv
lsu_tb.sv
